// ==== Bender.yml ====
package:
  name: stage_controller

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_isa_pkg.sv
      - rtl/pipe_ctrl_pkg.sv
      - rtl/load_use_detect.sv
      - rtl/redirect_ctrl.sv
      - rtl/stage_enable_merge.sv
      - rtl/stage_controller.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clock_gen.sv
      - test/tb_checker.sv
      - test/tb_stage_controller.sv

// ==== rtl/load_use_detect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pipe_ctrl_defines.svh"

module load_use_detect (
    input  wire logic [`PC_XLEN-1:0]   id_inst,      // instruction sitting in ID
    input  wire pipe_ctrl_pkg::sel_data_e exe_sel_data, // EXE result source, MEM on a load
    input  wire logic [`PC_REG_AW-1:0] exe_rd,       // EXE destination register
    output logic                       load_use      // ID reads what the EXE load writes
);

    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    opcode_e               id_opcode;
    logic [`PC_REG_AW-1:0] id_rs1;
    logic [`PC_REG_AW-1:0] id_rs2;
    logic                  rs1_used;  // opcode actually reads rs1
    logic                  rs2_used;  // opcode actually reads rs2
    logic                  exe_load;  // EXE holds a load with a real destination
    logic                  rs1_hit;
    logic                  rs2_hit;

    assign id_opcode = opcode_e'(id_inst[OPC_MSB:OPC_LSB]);
    assign id_rs1    = id_inst[RS1_MSB:RS1_LSB];
    assign id_rs2    = id_inst[RS2_MSB:RS2_LSB];

    // which source fields carry a register for this opcode
    always_comb begin
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (id_opcode)
            OP, STORE, BRANCH: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;                      // both operands from the rf
            end
            JALR, LOAD, OP_IMM: begin
                rs1_used = 1'b1;                      // base or first operand only
            end
            LUI, AUIPC, JAL: begin
                rs1_used = 1'b0;                      // those bits are immediate
                rs2_used = 1'b0;
            end
            default: begin
                rs1_used = 1'b0;                      // system, fence, unknown
                rs2_used = 1'b0;
            end
        endcase
    end

    // a load into x0 never produces a value worth waiting for
    assign exe_load = (exe_sel_data == MEM) && (exe_rd != '0);

    assign rs1_hit  = rs1_used && (id_rs1 == exe_rd);
    assign rs2_hit  = rs2_used && (id_rs2 == exe_rd);

    assign load_use = exe_load && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

// ==== rtl/pipe_ctrl_defines.svh ====
`ifndef PIPE_CTRL_DEFINES_SVH
`define PIPE_CTRL_DEFINES_SVH

// sizes shared by the stage controller blocks

`define PC_XLEN   32 // instruction word width

`define PC_REG_AW 5  // register file address width, x0..x31

`define PC_CNT_W  16 // event counter width, saturates at all ones

`endif

// ==== rtl/pipe_ctrl_pkg.sv ====
`default_nettype none

package pipe_ctrl_pkg;

    // result source selected in EXE for write-back
    typedef enum logic [1:0] {
        ALU = 2'd0, // alu result
        PC4 = 2'd1, // link address for jal/jalr
        IMM = 2'd2, // lui immediate
        MEM = 2'd3  // data memory, i.e. a load
    } sel_data_e;

    // redirect bookkeeping while the fetch buffer stalls
    typedef enum logic {
        IDLE    = 1'b0, // nothing outstanding
        PENDING = 1'b1  // redirect seen, new fetch still hidden by if_stall
    } redirect_state_e;

endpackage

`default_nettype wire

// ==== rtl/redirect_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module redirect_ctrl (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic branch_flush, // taken branch resolved in EXE
    input  wire logic is_jump,      // jal/jalr decoded in ID
    input  wire logic if_stall,     // fetch buffer has nothing to hand over
    input  wire logic id_hold,      // ID frozen by a load stall
    output logic      redirect_id,  // instruction fetched behind the redirect is wrong
    output logic      redirect_exe  // instruction decoded behind the branch is wrong
);

    import pipe_ctrl_pkg::*;

    redirect_state_e state;
    redirect_state_e next_state;
    logic            jump_taken;   // jump in ID that really leaves this cycle
    logic            new_redirect; // redirect raised this cycle
    logic            carried;      // redirect left over from a stalled fetch

    // a held jump comes back once the load stall clears
    assign jump_taken   = is_jump && !id_hold;
    assign new_redirect = branch_flush || jump_taken;

    assign carried      = (state == PENDING);

    assign redirect_exe = branch_flush;                  // only EXE branches reach ID/EXE
    assign redirect_id  = new_redirect || carried;

    // keep the redirect alive until a real fetch has gone by
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (new_redirect && if_stall) begin
                    next_state = PENDING;                // new fetch hidden by the stall
                end
            end
            PENDING: begin
                if (!if_stall) begin
                    next_state = IDLE;                   // wrong fetch flushed this cycle
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // after a cycle with if_stall low only a fresh redirect can flush ID
    a_pending_clears : assert property (
        @(posedge clk) disable iff (!rst_n)
        !if_stall |=> (redirect_id == new_redirect)
    ) else $error("redirect stayed pending past a cycle with if_stall low");

    // a stalled redirect is remembered, not dropped
    a_stall_remembered : assert property (
        @(posedge clk) disable iff (!rst_n)
        (new_redirect && if_stall) |=> redirect_id
    ) else $error("redirect lost during fetch stall");

endmodule

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

`include "pipe_ctrl_defines.svh"

package rv_isa_pkg;

    // RV32 base major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011, // lb/lh/lw/lbu/lhu
        MISC_MEM = 7'b0001111, // fence
        OP_IMM   = 7'b0010011, // addi and friends
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011, // sb/sh/sw
        OP       = 7'b0110011, // reg-reg alu ops
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011, // beq/bne/blt/bge/bltu/bgeu
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011  // ecall/ebreak/csr
    } opcode_e;

    // standard field positions within the instruction word
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;

    localparam int RS1_LSB = 15;                        // rs1 sits at [19:15]
    localparam int RS1_MSB = RS1_LSB + `PC_REG_AW - 1;

    localparam int RS2_LSB = 20;                        // rs2 sits at [24:20]
    localparam int RS2_MSB = RS2_LSB + `PC_REG_AW - 1;

endpackage

`default_nettype wire

// ==== rtl/stage_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pipe_ctrl_defines.svh"

module stage_controller (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  if_stall,     // compressed fetch buffer stall
    input  wire logic [`PC_XLEN-1:0]   id_inst,      // instruction in ID
    input  wire logic                  is_jump,      // taken jal/jalr in ID
    input  wire logic                  branch_flush, // branch redirect from EXE
    input  wire pipe_ctrl_pkg::sel_data_e exe_sel_data, // EXE write-back source
    input  wire logic [`PC_REG_AW-1:0] exe_rd,       // EXE destination register
    output logic                       if_en,
    output logic                       id_en,
    output logic                       id_flush,
    output logic                       exe_flush,
    output logic [`PC_CNT_W-1:0]       stall_cycles,
    output logic [`PC_CNT_W-1:0]       flush_count
);

    logic load_use;     // hazard from the decoder
    logic redirect_id;  // IF/ID bubble request
    logic redirect_exe; // ID/EXE bubble request
    logic id_hold;      // ID frozen, jumps there are not taken yet

    load_use_detect u_load_use_detect (
        .id_inst      (id_inst),
        .exe_sel_data (exe_sel_data),
        .exe_rd       (exe_rd),
        .load_use     (load_use)
    );

    redirect_ctrl u_redirect_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .branch_flush (branch_flush),
        .is_jump      (is_jump),
        .if_stall     (if_stall),
        .id_hold      (id_hold),
        .redirect_id  (redirect_id),
        .redirect_exe (redirect_exe)
    );

    // priorities and event counters
    stage_enable_merge u_stage_enable_merge (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_use     (load_use),
        .redirect_id  (redirect_id),
        .redirect_exe (redirect_exe),
        .if_stall     (if_stall),
        .if_en        (if_en),
        .id_en        (id_en),
        .id_flush     (id_flush),
        .exe_flush    (exe_flush),
        .id_hold      (id_hold),
        .stall_cycles (stall_cycles),
        .flush_count  (flush_count)
    );

endmodule

`default_nettype wire

// ==== rtl/stage_enable_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pipe_ctrl_defines.svh"

module stage_enable_merge (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 load_use,     // ID needs the EXE load result
    input  wire logic                 redirect_id,  // bubble into IF/ID requested
    input  wire logic                 redirect_exe, // branch taken in EXE
    input  wire logic                 if_stall,     // fetch buffer stall
    output logic                      if_en,        // PC and fetch advance
    output logic                      id_en,        // IF/ID register loads
    output logic                      id_flush,     // IF/ID loads a bubble
    output logic                      exe_flush,    // ID/EXE loads a bubble
    output logic                      id_hold,      // ID frozen by the load stall
    output logic [`PC_CNT_W-1:0]      stall_cycles, // load stall cycles, saturating
    output logic [`PC_CNT_W-1:0]      flush_count   // branches plus jumps, saturating
);

    logic stall_event;  // load stall that actually froze ID
    logic flush_event;  // fresh redirect this cycle
    logic redirect_q;   // last redirect was hidden by if_stall and is carried now

    // branch wins over everything, then the load stall, then fetch side
    always_comb begin
        if (redirect_exe) begin
            if_en     = 1'b1;                    // fetch from the branch target
            id_en     = 1'b1;
            id_flush  = 1'b1;                    // kill the wrong IF and ID pair
            exe_flush = 1'b1;
        end else if (load_use) begin
            if_en     = 1'b0;                    // freeze IF and ID
            id_en     = 1'b0;
            id_flush  = 1'b0;                    // jumps wait for the stall to clear
            exe_flush = 1'b1;                    // bubble behind the load
        end else begin
            if_en     = !if_stall;
            id_en     = 1'b1;                    // ID keeps draining
            id_flush  = redirect_id || if_stall; // no valid fetch to pass on
            exe_flush = 1'b0;
        end
    end

    assign id_hold     = load_use && !redirect_exe;

    assign stall_event = id_hold;
    // carried redirects were counted when they first showed up
    assign flush_event = redirect_exe || (redirect_id && !redirect_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= redirect_id && if_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_cycles <= '0;
            flush_count  <= '0;
        end else begin
            if (stall_event && stall_cycles != '1) begin
                stall_cycles <= stall_cycles + 1'b1; // holds at all ones
            end
            if (flush_event && flush_count != '1) begin
                flush_count <= flush_count + 1'b1;
            end
        end
    end

    // a held ID always bubbles EXE and never meets a branch
    a_branch_moves_id : assert property (
        @(posedge clk) disable iff (!rst_n)
        !id_en |-> (exe_flush && !redirect_exe)
    ) else $error("ID held without an EXE bubble or during a branch flush");

endmodule

`default_nettype wire

// ==== stage_controller.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/load_use_detect.sv
rtl/redirect_ctrl.sv
rtl/stage_enable_merge.sv
rtl/stage_controller.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_stage_controller.sv

// ==== test/stage_controller_patterns.txt ====
// test rst_n if_stall is_jump branch_flush id_inst sel rd | if_en id_en id_flush exe_flush | chk stall flush
// sel 0 = ALU, 3 = MEM (load); 00508333 OP add x6,x1,x5; 00508337 LUI; 000280e7 JALR x1,0(x5)
// test 1: load-use stall, LUI does not stall, load into x0 does not stall
01 1 0 0 0 00000013 0 00  1 1 0 0  1 0000 0000
01 1 0 0 0 00508333 3 05  0 0 0 1  0 0000 0000
01 1 0 0 0 00508337 3 05  1 1 0 0  0 0000 0000
01 1 0 0 0 00000333 3 00  1 1 0 0  0 0000 0000
01 1 0 0 0 00000013 0 00  1 1 0 0  1 0001 0000
// test 2: branch over a load-use hazard
02 1 0 0 1 00508333 3 05  1 1 1 1  1 0001 0000
02 1 0 0 0 00000013 0 00  1 1 0 0  1 0001 0001
// test 3: jump flushes ID only, jump held by a load stall waits
03 1 0 1 0 000280e7 0 00  1 1 1 0  1 0001 0001
03 1 0 0 0 00000013 0 00  1 1 0 0  1 0001 0002
03 1 0 1 0 000280e7 3 05  0 0 0 1  1 0001 0002
03 1 0 1 0 000280e7 0 00  1 1 1 0  1 0002 0002
03 1 0 0 0 00000013 0 00  1 1 0 0  1 0002 0003
// test 4: JALR during two if_stall cycles stays pending one cycle longer
04 1 1 1 0 000280e7 0 00  0 1 1 0  1 0002 0003
04 1 1 0 0 00000013 0 00  0 1 1 0  1 0002 0004
04 1 0 0 0 00000013 0 00  1 1 1 0  1 0002 0004
04 1 0 0 0 00000013 0 00  1 1 0 0  1 0002 0004
// test 5: totals, then reset clears the counters
05 1 0 0 0 00000013 0 00  1 1 0 0  1 0002 0004
05 0 0 0 0 00000013 0 00  1 1 0 0  0 0000 0000
05 1 0 0 0 00000013 0 00  1 1 0 0  1 0000 0000
05 1 0 0 0 00508333 3 05  0 0 0 1  1 0000 0000
05 1 0 0 0 00000013 0 00  1 1 0 0  1 0001 0000

// ==== test/tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pipe_ctrl_defines.svh"

module tb_checker (
    input  wire logic                 clk,
    input  wire logic                 check_en,      // a pattern row is being applied
    input  wire logic                 finish_req,    // all rows applied
    input  wire logic [7:0]           test_num,
    input  wire logic                 exp_if_en,
    input  wire logic                 exp_id_en,
    input  wire logic                 exp_id_flush,
    input  wire logic                 exp_exe_flush,
    input  wire logic                 check_cnt,     // row also checks the counters
    input  wire logic [`PC_CNT_W-1:0] exp_stall,
    input  wire logic [`PC_CNT_W-1:0] exp_flush,
    input  wire logic                 if_en,
    input  wire logic                 id_en,
    input  wire logic                 id_flush,
    input  wire logic                 exe_flush,
    input  wire logic [`PC_CNT_W-1:0] stall_cycles,
    input  wire logic [`PC_CNT_W-1:0] flush_count,
    output logic                      report_done,
    output logic [15:0]               tests_passed,
    output logic [15:0]               tests_failed
);

    import pipe_ctrl_pkg::*;

    logic [7:0] current_test = 8'd0; // 0 until the first row shows up
    int         test_errors  = 0;    // mismatches in the running test

    initial begin
        report_done  = 1'b0;
        tests_passed = '0;
        tests_failed = '0;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    // redirect FSM is the usual suspect when id_flush is off
    task automatic show_redirect_state();
        $display("  redirect state at this point is %s",
                 (tb_stage_controller.dut.u_redirect_ctrl.state == PENDING) ? "PENDING" : "IDLE");
    endtask

    task automatic close_test();
        if (current_test != 8'd0) begin
            if (test_errors == 0) begin
                $display("test %0d ok", current_test);
                tests_passed++;
            end else begin
                $display("test %0d has %0d mismatches", current_test, test_errors);
                tests_failed++;
            end
        end
        test_errors = 0;
    endtask

    always @(negedge clk) begin
        #1;                                        // 1 ns before the rising edge
        if (check_en) begin
            if (test_num != current_test) begin
                close_test();                      // new test number closes the old one
                current_test = test_num;
            end
            compare_value("if_en", exp_if_en, if_en);
            compare_value("id_en", exp_id_en, id_en);
            compare_value("id_flush", exp_id_flush, id_flush);
            if (id_flush !== exp_id_flush) begin
                show_redirect_state();
            end
            compare_value("exe_flush", exp_exe_flush, exe_flush);
            if (check_cnt) begin
                compare_value("stall_cycles", exp_stall, stall_cycles);
                compare_value("flush_count", exp_flush, flush_count);
            end
        end
    end

    always @(posedge finish_req) begin
        close_test();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        report_done = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2, // 4 ns clock
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // let go on a falling edge like every other input
    end

endmodule

`default_nettype wire

// ==== test/tb_stage_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pipe_ctrl_defines.svh"

module tb_stage_controller;

    import pipe_ctrl_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int ROW_W        = 15; // words per pattern row
    localparam int MAX_ROWS     = 64;
    localparam int TIMEOUT_PAD  = 20;

    logic                  clk;
    logic                  gen_rst_n;          // from the clock generator
    logic                  pat_rst_n;          // reset column of the patterns
    logic                  rst_n;
    logic                  if_stall;
    logic                  is_jump;
    logic                  branch_flush;
    logic [`PC_XLEN-1:0]   id_inst;
    sel_data_e             exe_sel_data;
    logic [`PC_REG_AW-1:0] exe_rd;
    logic                  if_en;
    logic                  id_en;
    logic                  id_flush;
    logic                  exe_flush;
    logic [`PC_CNT_W-1:0]  stall_cycles;
    logic [`PC_CNT_W-1:0]  flush_count;

    logic                  check_en;           // expectations below are live
    logic [7:0]            test_num;
    logic                  exp_if_en;
    logic                  exp_id_en;
    logic                  exp_id_flush;
    logic                  exp_exe_flush;
    logic                  check_cnt;
    logic [`PC_CNT_W-1:0]  exp_stall;
    logic [`PC_CNT_W-1:0]  exp_flush;
    logic                  finish_req;
    logic                  report_done;
    logic [15:0]           tests_passed;
    logic [15:0]           tests_failed;

    logic [31:0]           pat_mem [0:ROW_W*MAX_ROWS-1];
    int                    row_count   = 0;
    logic                  rows_loaded = 1'b0;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    assign rst_n = gen_rst_n && pat_rst_n;     // mid-run reset comes from the patterns

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk   (clk),
        .rst_n (gen_rst_n)
    );

    stage_controller dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_stall     (if_stall),
        .id_inst      (id_inst),
        .is_jump      (is_jump),
        .branch_flush (branch_flush),
        .exe_sel_data (exe_sel_data),
        .exe_rd       (exe_rd),
        .if_en        (if_en),
        .id_en        (id_en),
        .id_flush     (id_flush),
        .exe_flush    (exe_flush),
        .stall_cycles (stall_cycles),
        .flush_count  (flush_count)
    );

    tb_checker u_checker (
        .clk           (clk),
        .check_en      (check_en),
        .finish_req    (finish_req),
        .test_num      (test_num),
        .exp_if_en     (exp_if_en),
        .exp_id_en     (exp_id_en),
        .exp_id_flush  (exp_id_flush),
        .exp_exe_flush (exp_exe_flush),
        .check_cnt     (check_cnt),
        .exp_stall     (exp_stall),
        .exp_flush     (exp_flush),
        .if_en         (if_en),
        .id_en         (id_en),
        .id_flush      (id_flush),
        .exe_flush     (exe_flush),
        .stall_cycles  (stall_cycles),
        .flush_count   (flush_count),
        .report_done   (report_done),
        .tests_passed  (tests_passed),
        .tests_failed  (tests_failed)
    );

    // nop in ID, alu op in EXE, no stall or redirect
    task automatic drive_quiet();
        pat_rst_n    = 1'b1;
        if_stall     = 1'b0;
        is_jump      = 1'b0;
        branch_flush = 1'b0;
        id_inst      = 32'h0000_0013;
        exe_sel_data = ALU;
        exe_rd       = '0;
    endtask

    task automatic apply_row(input int row);
        int base;
        base          = row * ROW_W;
        test_num      = pat_mem[base][7:0];
        pat_rst_n     = pat_mem[base+1][0];
        if_stall      = pat_mem[base+2][0];
        is_jump       = pat_mem[base+3][0];
        branch_flush  = pat_mem[base+4][0];
        id_inst       = pat_mem[base+5];
        exe_sel_data  = sel_data_e'(pat_mem[base+6][1:0]);
        exe_rd        = pat_mem[base+7][`PC_REG_AW-1:0];
        exp_if_en     = pat_mem[base+8][0];
        exp_id_en     = pat_mem[base+9][0];
        exp_id_flush  = pat_mem[base+10][0];
        exp_exe_flush = pat_mem[base+11][0];
        check_cnt     = pat_mem[base+12][0];
        exp_stall     = pat_mem[base+13][`PC_CNT_W-1:0];
        exp_flush     = pat_mem[base+14][`PC_CNT_W-1:0];
        check_en      = 1'b1;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        drive_quiet();
        check_en   = 1'b0;
        finish_req = 1'b0;
        test_num   = 8'd0;
        {exp_if_en, exp_id_en, exp_id_flush, exp_exe_flush, check_cnt} = '0;
        exp_stall  = '0;
        exp_flush  = '0;
        $readmemh("test/stage_controller_patterns.txt", pat_mem);
        while (row_count < MAX_ROWS && !$isunknown(pat_mem[row_count*ROW_W])) begin
            row_count++;
        end
        if (row_count == 0) begin
            $display("error: no pattern rows could be read");
        end
        rows_loaded = 1'b1;
        wait (gen_rst_n === 1'b1);
        for (int i = 0; i < row_count; i++) begin
            @(negedge clk);
            apply_row(i);
        end
        @(negedge clk);
        drive_quiet();
        check_en   = 1'b0;
        finish_req = 1'b1;
        wait (report_done === 1'b1);
        if (tests_failed == 0 && tests_passed > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // every row is one cycle, so the run length is known up front
    initial begin
        wait (rows_loaded === 1'b1);
        cycle_limit = row_count + RESET_CYCLES + TIMEOUT_PAD;
        wait (cycle_count >= cycle_limit);
        $display("error: run still going after %0d cycles, stopped by the timeout", cycle_limit);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
